// ==== project.f ====
src/addrgen_pkg.sv
src/addrgen_cfg_decode.sv
src/addrgen_loop_nest.sv
src/addrgen_addr_issue.sv
src/addrgen_top.sv
verification/addrgen_tb_clock.sv
verification/addrgen_properties.sv
verification/addrgen_tb.sv

// ==== Makefile ====
# Verilator simulation of the strided address generator

VERILATOR ?= verilator
TOP       ?= addrgen_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

# build and run; the binary exits nonzero on $$fatal or a failed assertion
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/addrgen_tb.sv ====
/*
 * addrgen testbench
 * directed jobs checked against a nested-loop model of the address walk
 */

`timescale 1ns/100ps

module addrgen_tb;

  logic                    clk, rst_n;
  logic                    start, loop_outer, credit;
  addrgen_pkg::addr_t      base_addr, addr;
  addrgen_pkg::trans_cnt_t trans_size;
  addrgen_pkg::loop_cnt_t  line_length, feat_length, feat_roll;
  addrgen_pkg::stride_t    line_stride, feat_stride;
  logic                    addr_valid, busy, done;

  addrgen_pkg::addr_t exp_q[$];  // expected addresses of the running job
  logic [31:0]        rng;       // xorshift state
  int                 timeout_cycles;

  addrgen_tb_clock i_clock (.clk_o(clk), .rst_no(rst_n));

  addrgen_top i_dut (
    .clk_i(clk), .rst_ni(rst_n), .start_i(start), .base_addr_i(base_addr),
    .trans_size_i(trans_size), .line_length_i(line_length), .line_stride_i(line_stride),
    .feat_length_i(feat_length), .feat_stride_i(feat_stride), .feat_roll_i(feat_roll),
    .loop_outer_i(loop_outer), .credit_i(credit), .addr_o(addr),
    .addr_valid_o(addr_valid), .busy_o(busy), .done_o(done)
  );

  bind addrgen_top addrgen_properties i_props (
    .clk_i(clk_i), .rst_ni(rst_ni), .credit_i(credit_i),
    .addr_valid_i(addr_valid_o), .busy_i(busy_o), .done_i(done_o)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  // words inside lines inside features, roll picks the feature offset
  function automatic void build_expected();
    int words, lines, roll, ls, fs, k, l, w, feat_off;
    addrgen_pkg::addr_t base;
    words = int'(line_length);
    lines = int'(feat_length);
    roll  = (feat_roll > 1) ? int'(feat_roll) : 1; // 0 and 1 both mean no repeat
    ls    = int'($signed({line_stride[15:2], 2'b00})); // low bits ignored
    fs    = int'($signed({feat_stride[15:2], 2'b00}));
    base  = {base_addr[31:2], 2'b00};
    exp_q.delete();
    if (words == 0 || lines == 0) return;
    k = 0;
    while (exp_q.size() < int'(trans_size)) begin
      // outer repeats a feature roll times, inner cycles through roll features
      feat_off = loop_outer ? (k / roll) * fs : (k % roll) * fs;
      for (l = 0; l < lines; l++) begin
        for (w = 0; w < words; w++) begin
          if (exp_q.size() < int'(trans_size))
            exp_q.push_back(base + addrgen_pkg::addr_t'(
              feat_off + l * ls + w * int'(addrgen_pkg::WORD_STEP)));
        end
      end
      k++;
    end
  endfunction

  task automatic start_job(
    input addrgen_pkg::addr_t      base,
    input addrgen_pkg::trans_cnt_t size,
    input addrgen_pkg::loop_cnt_t  llen,
    input addrgen_pkg::stride_t    lstride,
    input addrgen_pkg::loop_cnt_t  flen,
    input addrgen_pkg::stride_t    fstride,
    input addrgen_pkg::loop_cnt_t  roll,
    input logic                    outer
  );
    int n;
    n = 0;
    @(negedge clk);
    while (busy) begin // previous job still draining
      @(negedge clk);
      n++;
      if (n > timeout_cycles) report_failure("DUT stayed busy, no start possible");
    end
    @(posedge clk);
    base_addr   <= base;
    trans_size  <= size;
    line_length <= llen;
    line_stride <= lstride;
    feat_length <= flen;
    feat_stride <= fstride;
    feat_roll   <= roll;
    loop_outer  <= outer;
    start       <= 1'b1;
    @(posedge clk); // start taken here
    start <= 1'b0;
    build_expected();
    @(negedge clk);
    assert (busy) else report_failure("busy did not rise after start");
  endtask

  // credits withheld for the first hold cycles and spaced out when random_return is set
  task automatic check_job(input string name, input int hold, input bit random_return);
    int got, owed, cycles, last_valid;
    bit finished;
    got        = 0;
    owed       = 0;
    cycles     = 0;
    last_valid = 0;
    finished   = 0;
    while (!finished) begin
      @(posedge clk);
      if (random_return) rng = next_random(rng);
      if (owed > 0 && cycles >= hold && (!random_return || rng[1:0] == 2'b00)) begin
        credit <= 1'b1;
        owed--;
      end else begin
        credit <= 1'b0;
      end
      @(negedge clk);
      cycles++;
      if (addr_valid) begin
        assert (got < exp_q.size())
          else report_failure($sformatf("%s: more addresses than expected", name));
        assert (addr == exp_q[got])
          else report_failure($sformatf("Mismatch %s item %0d expected %08h actual %08h",
                                        name, got, exp_q[got], addr));
        if (got == 0 && hold == 0)
          assert (cycles == 1)
            else report_failure($sformatf(
              "Mismatch %s first address cycle expected 1 actual %0d",
              name, cycles));
        got++;
        owed++;
        last_valid = cycles;
      end
      if (hold > 0 && cycles == hold)
        assert (got <= int'(addrgen_pkg::INIT_CREDITS))
          else report_failure($sformatf(
            "Mismatch %s addresses without credit return expected %0d actual %0d",
            name, int'(addrgen_pkg::INIT_CREDITS), got));
      if (done) begin
        finished = 1'b1;
        assert (!busy) else report_failure($sformatf("%s: busy still high with done", name));
        assert (cycles == last_valid + 1)
          else report_failure($sformatf("Mismatch %s done cycle expected %0d actual %0d",
                                        name, last_valid + 1, cycles));
      end else if (cycles > timeout_cycles) begin
        report_failure($sformatf("%s: timed out waiting for done", name));
      end
    end
    assert (got == exp_q.size())
      else report_failure($sformatf("Mismatch %s address count expected %0d actual %0d",
                                    name, exp_q.size(), got));
    while (owed > 0) begin // hand back what is still held
      @(posedge clk);
      credit <= 1'b1;
      owed--;
    end
    @(posedge clk);
    credit <= 1'b0;
  endtask

  task automatic single_loop();
    start_job(32'h1000_0003, 16'd20, 10'd20, 16'h0000, 10'd1, 16'h0000, 10'd1, 1'b0);
    check_job("single_loop", 0, 1'b0);
  endtask

  task automatic two_dim_walk();
    start_job(32'h0000_2000, 16'd12, 10'd4, 16'h0100, 10'd3, 16'h0000, 10'd1, 1'b0);
    check_job("two_dim_pos", 0, 1'b0);
    // negative stride with its low bits set
    start_job(32'h0000_8000, 16'd12, 10'd3, 16'hffc3, 10'd4, 16'h0000, 10'd1, 1'b0);
    check_job("two_dim_neg", 0, 1'b0);
    start_job(32'h0001_0000, 16'd24, 10'd3, 16'hff00, 10'd4, 16'h1000, 10'd0, 1'b1);
    check_job("two_dim_feat", 0, 1'b0);
  endtask

  task automatic inner_roll();
    start_job(32'h0000_4000, 16'd28, 10'd2, 16'h0010, 10'd2, 16'h0200, 10'd3, 1'b0);
    check_job("inner_roll", 0, 1'b0);
  endtask

  task automatic outer_roll();
    start_job(32'h0000_4000, 16'd28, 10'd2, 16'h0010, 10'd2, 16'h0200, 10'd3, 1'b1);
    check_job("outer_roll", 0, 1'b0);
  endtask

  task automatic credit_backpressure();
    start_job(32'h0000_9000, 16'd40, 10'd5, 16'h0040, 10'd3, 16'hfc00, 10'd2, 1'b1);
    check_job("backpressure", 20, 1'b1);
    start_job(32'h0000_a000, 16'd0, 10'd4, 16'h0040, 10'd1, 16'h0000, 10'd1, 1'b0);
    check_job("empty_job", 0, 1'b0);
  endtask

  initial begin
    int n;
    start          = 1'b0;
    base_addr      = '0;
    trans_size     = '0;
    line_length    = '0;
    line_stride    = '0;
    feat_length    = '0;
    feat_stride    = '0;
    feat_roll      = '0;
    loop_outer     = 1'b0;
    credit         = 1'b0;
    rng            = 32'h131d;
    timeout_cycles = 2000;
    n = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > 100) report_failure("reset was never released");
    end
    @(negedge clk);
    assert (!addr_valid && !busy && !done)
      else report_failure("outputs not idle after reset");
    single_loop();
    two_dim_walk();
    inner_roll();
    outer_roll();
    credit_backpressure();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== verification/addrgen_properties.sv ====
/*
 * addrgen properties
 * credit, done pulse and busy rules checked on the top level ports
 */

`timescale 1ns/100ps

module addrgen_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic credit_i,
  input logic addr_valid_i,
  input logic busy_i,
  input logic done_i
);

  // credit balance as seen from the port side
  // a valid in this cycle used a credit counted here
  addrgen_pkg::credit_cnt_t bal_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bal_q <= addrgen_pkg::INIT_CREDITS;
    end else begin
      bal_q <= bal_q + addrgen_pkg::credit_cnt_t'(credit_i)
                     - addrgen_pkg::credit_cnt_t'(addr_valid_i);
    end
  end

  valid_needs_credit: assert property (
    @(posedge clk_i) disable iff (!rst_ni) addr_valid_i |-> (bal_q != '0)
  ) else $error("address issued without an available credit");

  done_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i
  ) else $error("done held high for more than one cycle");

  valid_only_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !busy_i |-> !addr_valid_i
  ) else $error("address valid while the generator is idle");

  done_with_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |-> !busy_i
  ) else $error("done raised while still busy");

endmodule

// ==== verification/addrgen_tb_clock.sv ====
/*
 * addrgen testbench clock
 * 100 ns clock, active low reset held for the first 8 cycles
 */

`timescale 1ns/100ps

module addrgen_tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0; // in reset from time zero
  end

  always #50 clk_o = ~clk_o; // half of 100 ns

  initial begin
    repeat (8) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== src/addrgen_top.sv ====
/*
 * addrgen top
 * strided address generator with credit flow control
 */

`timescale 1ns/100ps

module addrgen_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // job config, sampled on start
  input  logic                    start_i,
  input  addrgen_pkg::addr_t      base_addr_i,
  input  addrgen_pkg::trans_cnt_t trans_size_i,
  input  addrgen_pkg::loop_cnt_t  line_length_i,
  input  addrgen_pkg::stride_t    line_stride_i,
  input  addrgen_pkg::loop_cnt_t  feat_length_i,
  input  addrgen_pkg::stride_t    feat_stride_i,
  input  addrgen_pkg::loop_cnt_t  feat_roll_i,
  input  logic                    loop_outer_i,
  // memory port side
  input  logic                    credit_i,
  output addrgen_pkg::addr_t      addr_o,
  output logic                    addr_valid_o,
  output logic                    busy_o,
  output logic                    done_o
);

  addrgen_pkg::addr_t      base_addr;
  addrgen_pkg::trans_cnt_t trans_last;
  addrgen_pkg::loop_cnt_t  word_last, line_last, roll_last;
  addrgen_pkg::stride_t    line_stride, feat_stride;
  addrgen_pkg::addr_t      offset;
  logic                    loop_outer;
  logic                    run, step, last_item, item_done;

  addrgen_cfg_decode i_decode (
    .clk_i, .rst_ni, .start_i, .base_addr_i, .trans_size_i,
    .line_length_i, .feat_length_i, .feat_roll_i,
    .line_stride_i, .feat_stride_i, .loop_outer_i,
    .item_done_i   (item_done),
    .base_addr_o   (base_addr),
    .trans_last_o  (trans_last),
    .word_last_o   (word_last),
    .line_last_o   (line_last),
    .roll_last_o   (roll_last),
    .line_stride_o (line_stride),
    .feat_stride_o (feat_stride),
    .loop_outer_o  (loop_outer),
    .run_o         (run),
    .busy_o,
    .done_o
  );

  addrgen_loop_nest i_loop_nest (
    .clk_i, .rst_ni,
    .step_i        (step),
    .start_i       (start_i && !busy_o), // start ignored mid job
    .word_last_i   (word_last),
    .line_last_i   (line_last),
    .roll_last_i   (roll_last),
    .line_stride_i (line_stride),
    .feat_stride_i (feat_stride),
    .loop_outer_i  (loop_outer),
    .trans_last_i  (trans_last),
    .offset_o      (offset),
    .last_item_o   (last_item)
  );

  addrgen_addr_issue i_issue (
    .clk_i, .rst_ni, .credit_i,
    .run_i         (run),
    .base_addr_i   (base_addr),
    .offset_i      (offset),
    .last_item_i   (last_item),
    .step_o        (step),
    .item_done_o   (item_done),
    .addr_o,
    .addr_valid_o
  );

endmodule

// ==== src/addrgen_addr_issue.sv ====
/*
 * addrgen address issue
 * credit counter, base plus offset, registered address output
 */

`timescale 1ns/100ps

module addrgen_addr_issue (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               run_i,        // job active
  input  logic               credit_i,     // one credit back per high cycle
  input  addrgen_pkg::addr_t base_addr_i,
  input  addrgen_pkg::addr_t offset_i,
  input  logic               last_item_i,
  output logic               step_o,       // advance the loop nest
  output logic               item_done_o,  // last address taken
  output addrgen_pkg::addr_t addr_o,
  output logic               addr_valid_o
);

  addrgen_pkg::credit_cnt_t credits_q, credits_d;
  addrgen_pkg::addr_t       addr_sum;
  addrgen_pkg::addr_t       addr_q;
  logic                     valid_q;
  logic                     credit_in; // accepted return

  // no credit, no address
  assign step_o      = run_i && (credits_q != '0);
  assign item_done_o = step_o && last_item_i;

  // downstream never overreturns, ceiling just keeps the count sane
  assign credit_in = credit_i && (credits_q != addrgen_pkg::MAX_CREDITS);

  always_comb begin
    credits_d = credits_q;
    case ({credit_in, step_o})
      2'b10:   credits_d = credits_q + addrgen_pkg::credit_cnt_t'(1);
      2'b01:   credits_d = credits_q - addrgen_pkg::credit_cnt_t'(1);
      default: credits_d = credits_q; // none, or one in one out
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= addrgen_pkg::INIT_CREDITS; // downstream slots
    end else begin
      credits_q <= credits_d;
    end
  end

  assign addr_sum = base_addr_i + offset_i;

  // address register, held while stalled
  always_ff @(posedge clk_i) begin
    if (step_o) begin
      addr_q <= {addr_sum[addrgen_pkg::ADDR_W-1:2], 2'b00}; // word aligned
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= step_o; // one valid per consumed credit
    end
  end

  assign addr_o       = addr_q;
  assign addr_valid_o = valid_q;

endmodule

// ==== src/addrgen_loop_nest.sv ====
/*
 * addrgen loop nest
 * word, line and feature counters with their byte offset accumulators,
 * plus the overall transaction count
 */

`timescale 1ns/100ps

module addrgen_loop_nest (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    step_i,      // advance one word
  input  logic                    start_i,     // accepted start, clears all
  input  addrgen_pkg::loop_cnt_t  word_last_i,
  input  addrgen_pkg::loop_cnt_t  line_last_i,
  input  addrgen_pkg::loop_cnt_t  roll_last_i,
  input  addrgen_pkg::stride_t    line_stride_i,
  input  addrgen_pkg::stride_t    feat_stride_i,
  input  logic                    loop_outer_i, // 1: outer roll, 0: inner roll
  input  addrgen_pkg::trans_cnt_t trans_last_i,
  output addrgen_pkg::addr_t      offset_o,
  output logic                    last_item_o
);

  // stride to full address width, keeps the sign
  function automatic addrgen_pkg::addr_t sext(input addrgen_pkg::stride_t s);
    sext = addrgen_pkg::addr_t'($signed(s));
  endfunction

  addrgen_pkg::loop_cnt_t  word_cnt_q;
  addrgen_pkg::loop_cnt_t  line_cnt_q;
  addrgen_pkg::loop_cnt_t  roll_cnt_q;
  addrgen_pkg::trans_cnt_t trans_cnt_q;
  addrgen_pkg::addr_t      word_off_q;
  addrgen_pkg::addr_t      line_off_q;
  addrgen_pkg::addr_t      feat_off_q;

  logic word_end; // last word of the line
  logic line_end; // last line of the feature
  logic roll_end; // roll counter about to wrap

  assign word_end    = (word_cnt_q == word_last_i);
  assign line_end    = (line_cnt_q == line_last_i);
  assign roll_end    = (roll_cnt_q >= roll_last_i);
  assign last_item_o = (trans_cnt_q == trans_last_i);

  // word and line loops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
      line_cnt_q <= '0;
      word_off_q <= '0;
      line_off_q <= '0;
    end else if (start_i) begin
      word_cnt_q <= '0;
      line_cnt_q <= '0;
      word_off_q <= '0;
      line_off_q <= '0;
    end else if (step_i) begin
      if (!word_end) begin
        word_cnt_q <= word_cnt_q + addrgen_pkg::loop_cnt_t'(1);
        word_off_q <= word_off_q + addrgen_pkg::WORD_STEP;
      end else if (!line_end) begin
        // next line of the same feature
        word_cnt_q <= '0;
        word_off_q <= '0;
        line_cnt_q <= line_cnt_q + addrgen_pkg::loop_cnt_t'(1);
        line_off_q <= line_off_q + sext(line_stride_i);
      end else begin
        word_cnt_q <= '0; // feature done, restart lines
        word_off_q <= '0;
        line_cnt_q <= '0;
        line_off_q <= '0;
      end
    end
  end

  // feature loop and roll
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      roll_cnt_q <= '0;
      feat_off_q <= '0;
    end else if (start_i) begin
      roll_cnt_q <= '0;
      feat_off_q <= '0;
    end else if (step_i && word_end && line_end) begin
      if (loop_outer_i) begin
        // outer: same features repeat, then move on
        if (roll_end) begin
          roll_cnt_q <= '0;
          feat_off_q <= feat_off_q + sext(feat_stride_i);
        end else begin
          roll_cnt_q <= roll_cnt_q + addrgen_pkg::loop_cnt_t'(1);
        end
      end else begin
        // inner: walk roll features, then back to the first
        if (roll_end) begin
          roll_cnt_q <= '0;
          feat_off_q <= '0;
        end else begin
          roll_cnt_q <= roll_cnt_q + addrgen_pkg::loop_cnt_t'(1);
          feat_off_q <= feat_off_q + sext(feat_stride_i);
        end
      end
    end
  end

  // overall transaction count, wraps to zero after the last item
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trans_cnt_q <= '0;
    end else if (start_i) begin
      trans_cnt_q <= '0;
    end else if (step_i) begin
      trans_cnt_q <= last_item_o ? '0 : trans_cnt_q + addrgen_pkg::trans_cnt_t'(1);
    end
  end

  assign offset_o = feat_off_q + line_off_q + word_off_q; // base added in issue

endmodule

// ==== src/addrgen_cfg_decode.sv ====
/*
 * addrgen config decode
 * latches the job at start, turns lengths into last indices, runs the job fsm
 */

`timescale 1ns/100ps

module addrgen_cfg_decode (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  addrgen_pkg::addr_t     base_addr_i,
  input  addrgen_pkg::trans_cnt_t trans_size_i,
  input  addrgen_pkg::loop_cnt_t line_length_i,
  input  addrgen_pkg::loop_cnt_t feat_length_i,
  input  addrgen_pkg::loop_cnt_t feat_roll_i,
  input  addrgen_pkg::stride_t   line_stride_i,
  input  addrgen_pkg::stride_t   feat_stride_i,
  input  logic                   loop_outer_i,
  input  logic                   item_done_i,   // last address issued
  output addrgen_pkg::addr_t     base_addr_o,
  output addrgen_pkg::trans_cnt_t trans_last_o,
  output addrgen_pkg::loop_cnt_t word_last_o,
  output addrgen_pkg::loop_cnt_t line_last_o,
  output addrgen_pkg::loop_cnt_t roll_last_o,
  output addrgen_pkg::stride_t   line_stride_o,
  output addrgen_pkg::stride_t   feat_stride_o,
  output logic                   loop_outer_o,
  output logic                   run_o,
  output logic                   busy_o,
  output logic                   done_o
);

  addrgen_pkg::run_state_e state_q, state_d;
  logic                    done_q;
  logic                    start_ok; // start seen while idle

  assign start_ok = start_i && (state_q == addrgen_pkg::ST_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      addrgen_pkg::ST_IDLE: begin
        // empty job skips straight to drain, no addresses
        if (start_i) state_d = (trans_size_i == '0) ? addrgen_pkg::ST_DRAIN : addrgen_pkg::ST_RUN;
      end
      addrgen_pkg::ST_RUN:   if (item_done_i) state_d = addrgen_pkg::ST_DRAIN;
      addrgen_pkg::ST_DRAIN: state_d = addrgen_pkg::ST_IDLE; // final addr on the port
      default:               state_d = addrgen_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= addrgen_pkg::ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == addrgen_pkg::ST_DRAIN); // one cycle, busy falls with it
    end
  end

  // job config, low two address bits dropped here
  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      base_addr_o   <= {base_addr_i[addrgen_pkg::ADDR_W-1:2], 2'b00};
      line_stride_o <= {line_stride_i[addrgen_pkg::STRIDE_W-1:2], 2'b00};
      feat_stride_o <= {feat_stride_i[addrgen_pkg::STRIDE_W-1:2], 2'b00};
      loop_outer_o  <= loop_outer_i;
      trans_last_o  <= trans_size_i - addrgen_pkg::trans_cnt_t'(1);
      word_last_o   <= line_length_i - addrgen_pkg::loop_cnt_t'(1);
      line_last_o   <= feat_length_i - addrgen_pkg::loop_cnt_t'(1);
      // roll of 0 or 1 means no repeat
      roll_last_o   <= (feat_roll_i > addrgen_pkg::loop_cnt_t'(1)) ?
                       feat_roll_i - addrgen_pkg::loop_cnt_t'(1) : '0;
    end
  end

  assign run_o  = (state_q == addrgen_pkg::ST_RUN);
  assign busy_o = (state_q != addrgen_pkg::ST_IDLE);
  assign done_o = done_q;

endmodule

// ==== src/addrgen_pkg.sv ====
/*
 * addrgen package
 * widths, word step, credit limits and the decode state encoding
 */

package addrgen_pkg;

  // field widths
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned TRANS_CNT_W = 16;
  localparam int unsigned LOOP_CNT_W  = 10;
  localparam int unsigned STRIDE_W    = 16;
  localparam int unsigned CREDIT_W    = 4;

  typedef logic [ADDR_W-1:0]      addr_t;       // byte address
  typedef logic [TRANS_CNT_W-1:0] trans_cnt_t;  // total transactions
  typedef logic [LOOP_CNT_W-1:0]  loop_cnt_t;   // word/line/feat counters
  typedef logic [STRIDE_W-1:0]    stride_t;     // signed byte stride
  typedef logic [CREDIT_W-1:0]    credit_cnt_t; // memory port credits

  // bytes per word, one address per word
  localparam addr_t WORD_STEP = addr_t'(4);

  // credits held after reset, equals downstream slots
  localparam credit_cnt_t INIT_CREDITS = credit_cnt_t'(4);
  localparam credit_cnt_t MAX_CREDITS  = credit_cnt_t'(15); // counter ceiling

  // decode fsm
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0, // waiting for start
    ST_RUN   = 2'd1, // walking the loop nest
    ST_DRAIN = 2'd2  // last address on the output, done next
  } run_state_e;

endpackage
